// ==== logic/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

`define RV_XLEN  32 // data and address width
`define RV_NREGS 32 // architectural registers, x0 included

// major opcodes, inst[6:0]
`define RV_OP_LUI    7'b011_0111
`define RV_OP_AUIPC  7'b001_0111
`define RV_OP_JAL    7'b110_1111
`define RV_OP_JALR   7'b110_0111
`define RV_OP_BRANCH 7'b110_0011
`define RV_OP_LOAD   7'b000_0011
`define RV_OP_STORE  7'b010_0011
`define RV_OP_IMM    7'b001_0011
`define RV_OP_REG    7'b011_0011
`define RV_OP_SYSTEM 7'b111_0011 // only ebreak is decoded

`endif

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  output word_t     imem_addr,
  input  word_t     imem_rdata,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output logic      halt
);

  word_t     pc;
  word_t     pc_plus4;
  word_t     pc_target;
  logic      take_branch;
  ctrl_t     ctrl;
  word_t     imm;
  reg_addr_t rs1, rs2, rd;
  word_t     rs1_data, rs2_data;
  word_t     alu_sum;
  word_t     wb_data;
  logic      reg_we;
  word_t     load_data;

  assign imem_addr = pc;
  assign halt      = ctrl.halt; // stays high since pc holds on ebreak

  rv_fetch u_fetch (
    .clk(clk), .arst_n(arst_n), .take_branch(take_branch), .pc_target(pc_target),
    .halt(ctrl.halt), .pc(pc), .pc_plus4(pc_plus4)
  );

  rv_decode u_decode (
    .inst(imem_rdata), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl)
  );

  rv_regfile u_regfile (
    .clk(clk), .arst_n(arst_n), .we(reg_we), .waddr(rd), .wdata(wb_data),
    .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_execute u_execute (
    .ctrl(ctrl), .pc(pc), .pc_plus4(pc_plus4), .imm(imm), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .load_data(load_data), .alu_sum(alu_sum), .pc_target(pc_target),
    .take_branch(take_branch), .wb_data(wb_data), .reg_we(reg_we)
  );

  rv_lsu u_lsu (
    .ctrl(ctrl), .addr(alu_sum), .store_data(rs2_data), .dmem_rdata(dmem_rdata),
    .dmem_req(dmem_req), .load_data(load_data)
  );

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output ctrl_t     ctrl
);

  logic [6:0] opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // sign-extended immediates, all from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000}; // already in the upper bits
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = funct3;
    imm         = '0;
    case (opcode)
      `RV_OP_LUI: begin
        // 0 + imm, no separate pass-through path
        ctrl.op_a_sel = OP_A_PC;
        ctrl.zero_a   = 1'b1;
        ctrl.use_imm  = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_u;
      end
      `RV_OP_AUIPC: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.use_imm  = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_u;
      end
      `RV_OP_JAL: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.use_imm  = 1'b1;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_sel   = WB_LINK;
        ctrl.is_jump  = 1'b1;
        imm           = imm_j;
      end
      `RV_OP_JALR: begin
        ctrl.use_imm = 1'b1; // rs1 + imm
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = WB_LINK;
        ctrl.is_jump = 1'b1;
        imm          = imm_i;
      end
      `RV_OP_BRANCH: begin
        ctrl.op_a_sel  = OP_A_PC; // adder forms the target
        ctrl.use_imm   = 1'b1;
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      `RV_OP_LOAD: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = WB_LOAD;
        ctrl.mem_re  = 1'b1;
        imm          = imm_i;
      end
      `RV_OP_STORE: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_we  = 1'b1;
        imm          = imm_s;
      end
      `RV_OP_IMM: begin
        ctrl.use_imm = 1'b1; // every funct3 runs as addi
        ctrl.reg_we  = 1'b1;
        imm          = imm_i;
      end
      `RV_OP_REG: begin
        ctrl.reg_we = 1'b1;
        ctrl.sub    = (funct3 == 3'b000) && (funct7 == 7'b010_0000);
      end
      `RV_OP_SYSTEM: ctrl.halt = 1'b1; // ebreak
      default: ;                          // unknown opcode acts as a nop
    endcase
  end

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t pc_plus4,
  input  word_t imm,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t load_data,
  output word_t alu_sum,
  output word_t pc_target,
  output logic  take_branch,
  output word_t wb_data,
  output logic  reg_we
);

  word_t       op_a, op_b;
  logic [32:0] cmp_diff; // rs1 - rs2 with borrow out
  logic        is_eq, is_lt, is_ltu;
  logic        cond;

  // operand select
  assign op_a = ctrl.zero_a ? '0 : ((ctrl.op_a_sel == OP_A_PC) ? pc : rs1_data);
  assign op_b = ctrl.use_imm ? imm : rs2_data;

  // add or sub through one adder, sub inverts b and adds the carry in
  assign alu_sum = op_a + (op_b ^ {32{ctrl.sub}}) + {31'd0, ctrl.sub};

  // branch compare kept off the main adder
  assign cmp_diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign is_eq    = (cmp_diff[31:0] == '0);
  assign is_ltu   = cmp_diff[32];
  assign is_lt    = (rs1_data[31] != rs2_data[31]) ? rs1_data[31] : cmp_diff[31];

  // funct3[2:1] picks the compare, funct3[0] inverts it
  always_comb begin
    case (ctrl.funct3[2:1])
      2'b00:   cond = is_eq;  // beq, bne
      2'b10:   cond = is_lt;  // blt, bge
      2'b11:   cond = is_ltu; // bltu, bgeu
      default: cond = 1'b0;
    endcase
    cond = cond ^ ctrl.funct3[0];
  end

  assign take_branch = ctrl.is_jump || (ctrl.is_branch && cond);

  // jal sums are even already, so clearing bit 0 only matters for jalr
  assign pc_target = ctrl.is_jump ? {alu_sum[31:1], 1'b0} : alu_sum;

  always_comb begin
    case (ctrl.wb_sel)
      WB_LINK: wb_data = pc_plus4;
      WB_LOAD: wb_data = load_data;
      default: wb_data = alu_sum;
    endcase
  end

  assign reg_we = ctrl.reg_we;

endmodule

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_fetch import rv_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  take_branch,
  input  word_t pc_target,
  input  logic  halt,
  output word_t pc,
  output word_t pc_plus4
);

  word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  // redirect wins, halt holds, otherwise sequential
  always_comb begin
    if (take_branch) begin
      next_pc = pc_target;
    end else if (halt) begin
      next_pc = pc;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // jalr targets come from rs1 + imm and could land off a word boundary
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  ctrl_t     ctrl,
  input  word_t     addr,
  input  word_t     store_data,
  input  word_t     dmem_rdata,
  output dmem_req_t dmem_req,
  output word_t     load_data
);

  logic [1:0] off;  // byte offset in the word
  logic [1:0] size; // 0 byte, 1 half, 2 word
  logic       misaligned;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  assign off  = addr[1:0];
  assign size = ctrl.funct3[1:0];

  assign misaligned = (size == 2'd3) ||
                      ((size == 2'd1) && off[0]) ||
                      ((size == 2'd2) && (off != 2'd0));

  // store side
  always_comb begin
    dmem_req.addr = addr;
    dmem_req.we   = ctrl.mem_we;
    dmem_req.re   = ctrl.mem_re;
    case (size)
      2'd0: begin
        dmem_req.wdata = {4{store_data[7:0]}}; // byte in every lane
        dmem_req.wstrb = 4'b0001 << off;
      end
      2'd1: begin
        dmem_req.wdata = {2{store_data[15:0]}};
        dmem_req.wstrb = 4'b0011 << off;
      end
      default: begin
        dmem_req.wdata = store_data;
        dmem_req.wstrb = 4'b1111;
      end
    endcase
    if (misaligned || !ctrl.mem_we) begin
      dmem_req.wstrb = '0; // misaligned store writes nothing
    end
  end

  // load side
  assign ld_byte = dmem_rdata[{off, 3'b000} +: 8];
  assign ld_half = off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};  // lb
      3'b001:  load_data = {{16{ld_half[15]}}, ld_half}; // lh
      3'b010:  load_data = dmem_rdata;                   // lw
      3'b100:  load_data = {24'd0, ld_byte};             // lbu
      3'b101:  load_data = {16'd0, ld_half};             // lhu
      default: load_data = '0;
    endcase
    if (misaligned) begin
      load_data = '0;
    end
    // decode must never mark an instruction as both load and store
    assert (!(dmem_req.we && dmem_req.re));
  end

endmodule

// ==== logic/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;   // data or address word
  typedef logic [4:0]          reg_addr_t;
  typedef logic [2:0]          funct3_t;
  typedef logic [3:0]          strb_t;   // one bit per byte lane

  // operand a source
  typedef logic op_a_sel_t;
  localparam op_a_sel_t OP_A_RS1 = 1'b0;
  localparam op_a_sel_t OP_A_PC  = 1'b1;

  // writeback source
  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_SUM  = 2'd0; // adder result
  localparam wb_sel_t WB_LINK = 2'd1; // pc + 4 for jal/jalr
  localparam wb_sel_t WB_LOAD = 2'd2; // extended load data

  // decoded control for one instruction
  typedef struct packed {
    op_a_sel_t op_a_sel;
    logic      zero_a;    // force operand a to zero, used by lui
    logic      use_imm;   // operand b is imm instead of rs2
    logic      sub;
    logic      reg_we;
    wb_sel_t   wb_sel;
    logic      is_branch;
    logic      is_jump;
    logic      mem_re;
    logic      mem_we;
    funct3_t   funct3;    // branch kind or access size
    logic      halt;
  } ctrl_t;

  // data port request, 70 bits
  typedef struct packed {
    word_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  we;
    logic  re;
  } dmem_req_t;

endpackage

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [0:`RV_NREGS-1];

  // x0 is cleared at reset and skipped on write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1]; // combinational read
  assign rdata2 = regs[raddr2];

  // writes of x0 from any instruction must never stick
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!arst_n) (raddr1 == '0) |-> (rdata1 == '0)
  ) else $error("x0 read back nonzero: %h", rdata1);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module rv_core_tb \
  -f rv_core.f -o rv_core_sim > build.log 2>&1 \
  && ./obj_dir/rv_core_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== rv_core.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_lsu.sv
logic/rv_core.sv
test/tb_clock.sv
test/rv_core_tb.sv

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_core_tb import rv_pkg::*; ();

  // instruction encoders in the RV32I field layouts
  function automatic word_t enc_i(logic [6:0] op, funct3_t f3, reg_addr_t rd,
                                  reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rd, reg_addr_t rs1,
                                  reg_addr_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, `RV_OP_REG};
  endfunction

  function automatic word_t enc_s(funct3_t f3, reg_addr_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `RV_OP_STORE}; // base is always x0
  endfunction

  function automatic word_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
                                  logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t enc_u(logic [6:0] op, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(reg_addr_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  localparam int N_PROG = 61;
  // x1 = 100 and x2 = -7 feed the branches
  // preset word 0x8182_f3f4 sits at 0x40
  localparam word_t PROG [0:N_PROG-1] = '{
    enc_i(`RV_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd100),   // 0  addi x1, x0, 100
    enc_i(`RV_OP_IMM, 3'b000, 5'd2, 5'd0, 12'hff9),   // 1  addi x2, x0, -7
    enc_r(7'h00, 5'd3, 5'd1, 5'd2),                   // 2  add x3 = 93
    enc_r(7'h20, 5'd4, 5'd1, 5'd2),                   // 3  sub x4 = 107
    enc_u(`RV_OP_LUI, 5'd5, 20'h81234),               // 4  lui x5
    enc_u(`RV_OP_AUIPC, 5'd6, 20'h00010),             // 5  auipc x6
    enc_s(3'b010, 5'd2, 12'h080),                     // 6  sw x2
    enc_s(3'b010, 5'd3, 12'h084),
    enc_s(3'b010, 5'd4, 12'h088),
    enc_s(3'b010, 5'd5, 12'h08c),
    enc_s(3'b010, 5'd6, 12'h090),                     // 10
    enc_b(3'b000, 5'd1, 5'd2, 13'd8),                 // 11 beq not taken
    enc_b(3'b001, 5'd1, 5'd1, 13'd8),                 // 12 bne not taken
    enc_b(3'b100, 5'd1, 5'd2, 13'd8),                 // 13 blt 100 < -7 not taken
    enc_b(3'b101, 5'd2, 5'd1, 13'd8),                 // 14 bge not taken
    enc_b(3'b110, 5'd2, 5'd1, 13'd8),                 // 15 bltu not taken
    enc_b(3'b111, 5'd1, 5'd2, 13'd8),                 // 16 bgeu not taken
    enc_b(3'b000, 5'd1, 5'd1, 13'd8),                 // 17 beq -> 19
    enc_b(3'b001, 5'd1, 5'd2, 13'd8),                 // 18 bne -> 20
    enc_b(3'b100, 5'd2, 5'd1, 13'h1ffc),              // 19 blt -> 18
    enc_b(3'b101, 5'd1, 5'd2, 13'd8),                 // 20 bge -> 22
    enc_b(3'b111, 5'd2, 5'd1, 13'd8),                 // 21 bgeu -> 23
    enc_b(3'b110, 5'd1, 5'd2, 13'h1ffc),              // 22 bltu -> 21
    enc_j(5'd7, 21'd8),                               // 23 jal x7 -> 25
    enc_j(5'd0, 21'd8),                               // 24 jal x0 -> 26
    enc_i(`RV_OP_JALR, 3'b000, 5'd8, 5'd7, 12'd1),    // 25 jalr x8, 1(x7) -> 24
    enc_s(3'b010, 5'd7, 12'h094),                     // 26
    enc_s(3'b010, 5'd8, 12'h098),
    enc_i(`RV_OP_LOAD, 3'b000, 5'd9, 5'd0, 12'h040),  // 28 lb
    enc_s(3'b010, 5'd9, 12'h09c),
    enc_i(`RV_OP_LOAD, 3'b000, 5'd9, 5'd0, 12'h041),
    enc_s(3'b010, 5'd9, 12'h0a0),
    enc_i(`RV_OP_LOAD, 3'b000, 5'd9, 5'd0, 12'h042),
    enc_s(3'b010, 5'd9, 12'h0a4),
    enc_i(`RV_OP_LOAD, 3'b000, 5'd9, 5'd0, 12'h043),
    enc_s(3'b010, 5'd9, 12'h0a8),
    enc_i(`RV_OP_LOAD, 3'b100, 5'd9, 5'd0, 12'h040),  // 36 lbu
    enc_s(3'b010, 5'd9, 12'h0ac),
    enc_i(`RV_OP_LOAD, 3'b100, 5'd9, 5'd0, 12'h041),
    enc_s(3'b010, 5'd9, 12'h0b0),
    enc_i(`RV_OP_LOAD, 3'b100, 5'd9, 5'd0, 12'h042),
    enc_s(3'b010, 5'd9, 12'h0b4),
    enc_i(`RV_OP_LOAD, 3'b100, 5'd9, 5'd0, 12'h043),
    enc_s(3'b010, 5'd9, 12'h0b8),
    enc_i(`RV_OP_LOAD, 3'b001, 5'd9, 5'd0, 12'h040),  // 44 lh
    enc_s(3'b010, 5'd9, 12'h0bc),
    enc_i(`RV_OP_LOAD, 3'b001, 5'd9, 5'd0, 12'h042),
    enc_s(3'b010, 5'd9, 12'h0c0),
    enc_i(`RV_OP_LOAD, 3'b101, 5'd9, 5'd0, 12'h040),  // 48 lhu
    enc_s(3'b010, 5'd9, 12'h0c4),
    enc_i(`RV_OP_LOAD, 3'b101, 5'd9, 5'd0, 12'h042),
    enc_s(3'b010, 5'd9, 12'h0c8),
    enc_i(`RV_OP_LOAD, 3'b010, 5'd9, 5'd0, 12'h040),  // 52 lw
    enc_s(3'b010, 5'd9, 12'h0cc),
    enc_s(3'b000, 5'd9, 12'h0d0),                     // 54 sb at each offset
    enc_s(3'b000, 5'd9, 12'h0d1),
    enc_s(3'b000, 5'd9, 12'h0d2),
    enc_s(3'b000, 5'd9, 12'h0d3),
    enc_s(3'b001, 5'd9, 12'h0d4),                     // 58 sh
    enc_s(3'b001, 5'd9, 12'h0d6),
    enc_i(`RV_OP_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h001) // 60 ebreak
  };

  typedef struct packed {
    word_t addr;
    word_t data;
    strb_t strb;
  } store_t;

  localparam int N_STORE = 26;
  localparam store_t STORES [0:N_STORE-1] = '{
    {32'h0000_0080, 32'hffff_fff9, 4'hf}, // addi -7
    {32'h0000_0084, 32'h0000_005d, 4'hf}, // 100 + -7
    {32'h0000_0088, 32'h0000_006b, 4'hf}, // 100 - -7
    {32'h0000_008c, 32'h8123_4000, 4'hf},
    {32'h0000_0090, 32'h8001_0014, 4'hf}, // pc 0x8000_0014 + 0x10000
    {32'h0000_0094, 32'h8000_0060, 4'hf}, // jal link
    {32'h0000_0098, 32'h8000_0068, 4'hf}, // jalr link
    {32'h0000_009c, 32'hffff_fff4, 4'hf},
    {32'h0000_00a0, 32'hffff_fff3, 4'hf},
    {32'h0000_00a4, 32'hffff_ff82, 4'hf},
    {32'h0000_00a8, 32'hffff_ff81, 4'hf},
    {32'h0000_00ac, 32'h0000_00f4, 4'hf},
    {32'h0000_00b0, 32'h0000_00f3, 4'hf},
    {32'h0000_00b4, 32'h0000_0082, 4'hf},
    {32'h0000_00b8, 32'h0000_0081, 4'hf},
    {32'h0000_00bc, 32'hffff_f3f4, 4'hf},
    {32'h0000_00c0, 32'hffff_8182, 4'hf},
    {32'h0000_00c4, 32'h0000_f3f4, 4'hf},
    {32'h0000_00c8, 32'h0000_8182, 4'hf},
    {32'h0000_00cc, 32'h8182_f3f4, 4'hf},
    {32'h0000_00d0, 32'hf4f4_f4f4, 4'h1}, // byte replicated in all lanes
    {32'h0000_00d1, 32'hf4f4_f4f4, 4'h2},
    {32'h0000_00d2, 32'hf4f4_f4f4, 4'h4},
    {32'h0000_00d3, 32'hf4f4_f4f4, 4'h8},
    {32'h0000_00d4, 32'hf3f4_f3f4, 4'h3},
    {32'h0000_00d6, 32'hf3f4_f3f4, 4'hc}
  };

  // program index fetched in each cycle
  localparam int N_FETCH = 61;
  localparam int FETCH_IDX [0:N_FETCH-1] = '{
    0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17,
    19, 18, 20, 22, 21, 23, 25, 24,
    26, 27, 28, 29, 30, 31, 32, 33, 34, 35, 36, 37, 38, 39, 40, 41, 42, 43,
    44, 45, 46, 47, 48, 49, 50, 51, 52, 53, 54, 55, 56, 57, 58, 59, 60
  };

  localparam int TIMEOUT = N_FETCH + 20;

  logic      clk;
  logic      arst_n;
  word_t     imem_addr;
  word_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;

  word_t imem [0:63];
  word_t dmem [0:63];
  int    n_checks;
  int    n_errors;
  int    st_ptr;
  int    cycles;

  tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(clk));

  rv_core dut (
    .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .halt(halt)
  );

  // combinational word-addressed memories
  assign imem_rdata = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    if (dmem_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wstrb[b]) begin
          dmem[dmem_req.addr[7:2]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  always @(posedge clk) begin
    if (arst_n) begin
      cycles++;
    end
    if (cycles > TIMEOUT) begin
      $display("timeout: program did not finish within %0d cycles", TIMEOUT);
      $display("checks %0d, errors %0d", n_checks, n_errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    word_t exp_pc;
    word_t last_pc;
    word_t inst;
    arst_n   = 1'b0;
    n_checks = 0;
    n_errors = 0;
    st_ptr   = 0;
    cycles   = 0;
    last_pc  = `RV_RESET_PC + 32'((N_PROG - 1) * 4);
    for (int k = 0; k < 64; k++) begin
      imem[k] = '0;
      dmem[k] = '0;
      if (k < N_PROG) begin
        imem[k] = PROG[k];
      end
    end
    dmem[16] = 32'h8182_f3f4; // byte address 0x40
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    for (int i = 0; i < N_FETCH; i++) begin
      exp_pc = `RV_RESET_PC + 32'(FETCH_IDX[i] * 4);
      inst   = PROG[FETCH_IDX[i]];
      check_word("imem_addr", imem_addr, exp_pc);
      check_word("halt", {31'd0, halt}, {31'd0, FETCH_IDX[i] == N_PROG - 1});
      // only loads read and only stores write
      check_word("dmem_req.re", {31'd0, dmem_req.re}, {31'd0, inst[6:0] == `RV_OP_LOAD});
      check_word("dmem_req.we", {31'd0, dmem_req.we}, {31'd0, inst[6:0] == `RV_OP_STORE});
      if (dmem_req.we) begin
        if (st_ptr >= N_STORE) begin
          n_errors++;
          $display("store to %h after the last expected store", dmem_req.addr);
        end else begin
          check_word("dmem_req.addr", dmem_req.addr, STORES[st_ptr].addr);
          check_word("dmem_req.wdata", dmem_req.wdata, STORES[st_ptr].data);
          check_word("dmem_req.wstrb", {28'd0, dmem_req.wstrb}, {28'd0, STORES[st_ptr].strb});
          st_ptr++;
        end
      end
      @(negedge clk);
    end

    // pc must hold on ebreak
    for (int k = 0; k < 3; k++) begin
      check_word("imem_addr", imem_addr, last_pc);
      check_word("halt", {31'd0, halt}, 32'd1);
      @(negedge clk);
    end
    if (st_ptr != N_STORE) begin
      n_errors++;
      $display("only %0d of %0d expected stores were seen", st_ptr, N_STORE);
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk; // 50% duty
  end

endmodule
